//--- vga_pkg.sv
// Shared types for the VGA scan-out engine
// Raster geometry, FIFO entry, colour and fetch state definitions
package vga_pkg;

  // Words fetched per burst
  localparam int BURST_LEN = 8;

  // Line and frame geometry, positions run 0 to total-1
  // Sync active from sync_start up to but not including sync_end
  typedef struct packed {
    logic [9:0] h_total;
    logic [9:0] h_visible;
    logic [9:0] h_sync_start;
    logic [9:0] h_sync_end;
    logic [9:0] v_total;
    logic [9:0] v_visible;
    logic [9:0] v_sync_start;
    logic [9:0] v_sync_end;
  } raster_cfg_t;

  // One raster position with its palette index
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       video_on;
    logic [7:0] pix_index;
  } fifo_entry_t;

  // 12-bit colour
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // Burst fetch FSM
  typedef enum logic [2:0] {
    IDLE,
    CACHE_REQ,
    CACHE_BEAT,
    MEM_REQ,
    MEM_BEAT
  } fetch_state_e;

endpackage

//--- raster_timing.sv
// Raster position counters for the scan-out engine
// Sync and video-on decode per fetched word, frame end flag
`timescale 1ns/1ps

module raster_timing (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_pkg::raster_cfg_t cfg_i,
  input  logic                 adv_i,
  output vga_pkg::fifo_entry_t beat_o,
  output logic                 frame_end_o
);

  import vga_pkg::*;

  // Current raster position
  logic [9:0] h_cnt;
  logic [9:0] v_cnt;

  // Last column of a line and last line of a frame
  logic h_last;
  logic v_last;

  // Decoded windows
  logic h_sync;
  logic v_sync;
  logic h_vis;
  logic v_vis;

  assign h_last = (h_cnt == cfg_i.h_total - 10'd1);
  assign v_last = (v_cnt == cfg_i.v_total - 10'd1);

  // One step per word consumed by the fetch side
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= 10'd0;
      v_cnt <= 10'd0;
    end else if (adv_i) begin
      if (h_last) begin
        h_cnt <= 10'd0;
        // Next line, wrap at frame end
        if (v_last) begin
          v_cnt <= 10'd0;
        end else begin
          v_cnt <= v_cnt + 10'd1;
        end
      end else begin
        h_cnt <= h_cnt + 10'd1;
      end
    end
  end

  // Sync windows, start inclusive and end exclusive
  assign h_sync = (h_cnt >= cfg_i.h_sync_start) && (h_cnt < cfg_i.h_sync_end);
  assign v_sync = (v_cnt >= cfg_i.v_sync_start) && (v_cnt < cfg_i.v_sync_end);

  // Visible area
  assign h_vis = (h_cnt < cfg_i.h_visible);
  assign v_vis = (v_cnt < cfg_i.v_visible);

  // Beat for the current position, index filled in by the fetch side
  always_comb begin
    beat_o           = '0;
    beat_o.hsync     = h_sync;
    beat_o.vsync     = v_sync;
    beat_o.video_on  = h_vis && v_vis;
    beat_o.pix_index = 8'd0;
  end

  // Sitting on the final position of the frame
  assign frame_end_o = h_last && v_last;

endmodule

//--- burst_fetch.sv
// Burst fetch controller for the pixel FIFO
// Cache attempt with memory fallback, burst base and FIFO write path
`timescale 1ns/1ps

module burst_fetch #(
  parameter int ADR_W   = 20,
  parameter int FIFO_AW = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [ADR_W-1:0]     start_addr_i,
  input  logic                 frame_end_i,
  input  vga_pkg::fifo_entry_t beat_i,
  input  logic [FIFO_AW:0]     fifo_level_i,
  // Direct cache port
  output logic                 dcb_stb_o,
  output logic [ADR_W-1:0]     dcb_adr_o,
  input  logic [15:0]          dcb_dat_i,
  input  logic                 dcb_hit_i,
  // Memory port, read only
  output logic                 mem_stb_o,
  output logic [ADR_W-1:0]     mem_adr_o,
  input  logic                 mem_ack_i,
  input  logic [15:0]          mem_dat_i,
  // Raster advance and FIFO write
  output logic                 adv_o,
  output logic                 wr_en_o,
  output vga_pkg::fifo_entry_t wr_data_o
);

  import vga_pkg::*;

  localparam int BW    = $clog2(BURST_LEN);
  localparam int DEPTH = 1 << FIFO_AW;

  typedef logic [BW-1:0]    beat_t;
  typedef logic [FIFO_AW:0] level_t;

  localparam beat_t  LAST_BEAT = beat_t'(BURST_LEN - 1);
  // Room for a whole burst
  localparam level_t START_LVL = level_t'(DEPTH - BURST_LEN);

  fetch_state_e state;
  fetch_state_e next_state;

  // Word within the burst
  beat_t beat_q;
  logic  last_beat;

  // Burst base address
  logic [ADR_W-1:0] base_q;

  // Cache address offset from the base
  logic [BW:0] dcb_off;

  logic        can_burst;
  logic        use_cache;
  logic        wr_en;
  logic [15:0] word;

  assign can_burst = (fifo_level_i <= START_LVL);
  assign last_beat = (beat_q == LAST_BEAT);

  // Next state and port strobes
  always_comb begin
    next_state = state;
    dcb_stb_o  = 1'b0;
    mem_stb_o  = 1'b0;
    use_cache  = 1'b0;
    wr_en      = 1'b0;
    dcb_off    = '0;
    case (state)
      IDLE: begin
        if (can_burst) begin
          next_state = CACHE_REQ;
        end
      end
      CACHE_REQ: begin
        // Base address goes out first
        dcb_stb_o = 1'b1;
        next_state = CACHE_BEAT;
      end
      CACHE_BEAT: begin
        use_cache = 1'b1;
        // Address runs one ahead of the answer
        dcb_off   = {1'b0, beat_q} + 1'b1;
        if (beat_q == beat_t'(0) && !dcb_hit_i) begin
          // Miss, cache port drops
          next_state = MEM_REQ;
        end else begin
          wr_en     = 1'b1;
          // Line stays locked until the last word
          dcb_stb_o = !last_beat;
          if (last_beat) begin
            next_state = IDLE;
          end
        end
      end
      MEM_REQ: begin
        mem_stb_o = 1'b1;
        // Ack cycle carries word 0
        if (mem_ack_i) begin
          wr_en      = 1'b1;
          next_state = MEM_BEAT;
        end
      end
      MEM_BEAT: begin
        // Remaining words, no further ack
        wr_en = 1'b1;
        if (last_beat) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      beat_q <= '0;
      base_q <= start_addr_i;
    end else begin
      state <= next_state;
      // Counter wraps to 0 after the eighth word
      if (wr_en) begin
        beat_q <= beat_q + 1'b1;
      end
      // Step the base, back to the start after the frame's last word
      if (wr_en && last_beat) begin
        if (frame_end_i) begin
          base_q <= start_addr_i;
        end else begin
          base_q <= base_q + ADR_W'(BURST_LEN);
        end
      end
    end
  end

  assign dcb_adr_o = base_q + ADR_W'(dcb_off);
  assign mem_adr_o = base_q;

  // Word source per beat
  assign word = use_cache ? dcb_dat_i : mem_dat_i;

  // Each word consumes one raster position
  assign adv_o   = wr_en;
  assign wr_en_o = wr_en;

  // Raster beat plus palette index from the low byte
  always_comb begin
    wr_data_o           = beat_i;
    wr_data_o.pix_index = word[7:0];
  end

endmodule

//--- pixel_fifo.sv
// Synchronous FIFO of raster entries
// Register array, fill level, head shown without latency
`timescale 1ns/1ps

module pixel_fifo #(
  parameter int FIFO_AW = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_en_i,
  input  vga_pkg::fifo_entry_t wr_data_i,
  input  logic                 rd_en_i,
  output vga_pkg::fifo_entry_t rd_data_o,
  output logic [FIFO_AW:0]     level_o,
  output logic                 empty_o
);

  import vga_pkg::*;

  localparam int DEPTH = 1 << FIFO_AW;

  fifo_entry_t mem [DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   level;

  logic full;
  logic do_wr;
  logic do_rd;

  assign full  = level[FIFO_AW];
  assign do_wr = wr_en_i && !full;
  assign do_rd = rd_en_i && !empty_o;

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // Pointers and level
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous read and write keep the level
      level <= level + (do_wr ? 1'b1 : 1'b0) - (do_rd ? 1'b1 : 1'b0);
    end
  end

  // First word fall through
  assign rd_data_o = mem[rd_ptr];
  assign level_o   = level;
  assign empty_o   = (level == '0);

endmodule

//--- palette_out.sv
// Output stage with one pixel every four clocks
// FIFO read, 16-entry palette, registered RGB and syncs, underflow flag
`timescale 1ns/1ps

module palette_out (
  input  logic                 clk,
  input  logic                 rst,
  // Palette write
  input  logic                 pal_we_i,
  input  logic [3:0]           pal_addr_i,
  input  vga_pkg::rgb_t        pal_data_i,
  // FIFO read side
  input  logic                 fifo_empty_i,
  input  vga_pkg::fifo_entry_t fifo_data_i,
  output logic                 fifo_rd_o,
  // Video out
  output vga_pkg::rgb_t        rgb_o,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 pix_stb_o,
  output logic                 underflow_o
);

  import vga_pkg::*;

  rgb_t palette [16];

  // Pixel beat phase
  logic [1:0] pix_cnt;

  // Entry taken on phase 1
  fifo_entry_t ent_q;
  logic        got_q;
  // Set by the first successful read
  logic        run_q;

  // Palette can change at any time
  always_ff @(posedge clk) begin
    if (pal_we_i) begin
      palette[pal_addr_i] <= pal_data_i;
    end
  end

  assign fifo_rd_o = (pix_cnt == 2'd1) && !fifo_empty_i;

  // Payload capture
  always_ff @(posedge clk) begin
    if (fifo_rd_o) begin
      ent_q <= fifo_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pix_cnt     <= 2'd0;
      got_q       <= 1'b0;
      run_q       <= 1'b0;
      rgb_o       <= '0;
      hsync_o     <= 1'b0;
      vsync_o     <= 1'b0;
      pix_stb_o   <= 1'b0;
      underflow_o <= 1'b0;
    end else begin
      pix_cnt     <= pix_cnt + 2'd1;
      pix_stb_o   <= 1'b0;
      underflow_o <= 1'b0;
      if (pix_cnt == 2'd1) begin
        got_q <= !fifo_empty_i;
        if (!fifo_empty_i) run_q <= 1'b1;
      end
      // Drive the pixel once the stream has started
      if (pix_cnt == 2'd2 && run_q) begin
        pix_stb_o   <= 1'b1;
        underflow_o <= !got_q;
        // Black in blanking and on underflow
        rgb_o <= (got_q && ent_q.video_on) ? palette[ent_q.pix_index[3:0]] : '0;
        // Empty read keeps the previous syncs
        if (got_q) begin
          hsync_o <= ent_q.hsync;
          vsync_o <= ent_q.vsync;
        end
      end
    end
  end

endmodule

//--- vga_scanout.sv
// Top level of the VGA scan-out engine
// Raster timing, burst fetch, pixel FIFO and palette stage
`timescale 1ns/1ps

module vga_scanout #(
  parameter int ADR_W   = 20,
  parameter int FIFO_AW = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  // Configuration
  input  vga_pkg::raster_cfg_t cfg_i,
  input  logic [ADR_W-1:0]     start_addr_i,
  // Palette write
  input  logic                 pal_we_i,
  input  logic [3:0]           pal_addr_i,
  input  vga_pkg::rgb_t        pal_data_i,
  // Cache port
  output logic                 dcb_stb_o,
  output logic [ADR_W-1:0]     dcb_adr_o,
  input  logic [15:0]          dcb_dat_i,
  input  logic                 dcb_hit_i,
  // Memory port
  output logic                 mem_stb_o,
  output logic [ADR_W-1:0]     mem_adr_o,
  input  logic                 mem_ack_i,
  input  logic [15:0]          mem_dat_i,
  // Video
  output vga_pkg::rgb_t        rgb_o,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 pix_stb_o,
  output logic                 underflow_o
);

  import vga_pkg::*;

  // Raster to fetch
  logic        adv;
  fifo_entry_t beat;
  logic        frame_end;

  // Fetch to FIFO
  logic             wr_en;
  fifo_entry_t      wr_data;
  logic [FIFO_AW:0] fifo_level;

  // FIFO to output stage
  logic        rd_en;
  fifo_entry_t rd_data;
  logic        fifo_empty;

  raster_timing i_raster (
    .clk, .rst, .cfg_i,
    .adv_i(adv), .beat_o(beat), .frame_end_o(frame_end)
  );

  burst_fetch #(.ADR_W(ADR_W), .FIFO_AW(FIFO_AW)) i_fetch (
    .clk, .rst, .start_addr_i,
    .frame_end_i(frame_end), .beat_i(beat), .fifo_level_i(fifo_level),
    .dcb_stb_o, .dcb_adr_o, .dcb_dat_i, .dcb_hit_i,
    .mem_stb_o, .mem_adr_o, .mem_ack_i, .mem_dat_i,
    .adv_o(adv), .wr_en_o(wr_en), .wr_data_o(wr_data)
  );

  pixel_fifo #(.FIFO_AW(FIFO_AW)) i_fifo (
    .clk, .rst,
    .wr_en_i(wr_en), .wr_data_i(wr_data),
    .rd_en_i(rd_en), .rd_data_o(rd_data),
    .level_o(fifo_level), .empty_o(fifo_empty)
  );

  palette_out i_pal (
    .clk, .rst, .pal_we_i, .pal_addr_i, .pal_data_i,
    .fifo_empty_i(fifo_empty), .fifo_data_i(rd_data), .fifo_rd_o(rd_en),
    .rgb_o, .hsync_o, .vsync_o, .pix_stb_o, .underflow_o
  );

endmodule

//--- vga_scanout_assert.sv
// Concurrent checks on the fetch controller and the pixel FIFO
// Bound into burst_fetch and pixel_fifo, unused inputs tied low
`timescale 1ns/1ps

module vga_scanout_assert (
  input logic clk,
  input logic rst,
  // FIFO write side
  input logic wr_en_i,
  input logic full_i,
  // Fetch ports
  input logic mem_stb_i,
  input logic mem_ack_i,
  input logic dcb_stb_i
);

  // Start rule keeps room for the whole burst
  property no_write_when_full;
    @(posedge clk) disable iff (rst) !(wr_en_i && full_i);
  endproperty

  // Request stays up until acknowledged
  property mem_stb_held;
    @(posedge clk) disable iff (rst) (mem_stb_i && !mem_ack_i) |=> mem_stb_i;
  endproperty

  // One port at a time
  property ports_exclusive;
    @(posedge clk) disable iff (rst) !(dcb_stb_i && mem_stb_i);
  endproperty

  a_no_write_when_full : assert property (no_write_when_full)
    else $error("FIFO written while full");
  a_mem_stb_held : assert property (mem_stb_held)
    else $error("mem_stb_o dropped before mem_ack_i");
  a_ports_exclusive : assert property (ports_exclusive)
    else $error("dcb_stb_o and mem_stb_o high together");

endmodule

bind burst_fetch vga_scanout_assert i_fetch_chk (
  .clk(clk), .rst(rst), .wr_en_i(1'b0), .full_i(1'b0),
  .mem_stb_i(mem_stb_o), .mem_ack_i(mem_ack_i), .dcb_stb_i(dcb_stb_o)
);

bind pixel_fifo vga_scanout_assert i_fifo_chk (
  .clk(clk), .rst(rst), .wr_en_i(wr_en_i), .full_i(full),
  .mem_stb_i(1'b0), .mem_ack_i(1'b0), .dcb_stb_i(1'b0)
);

//--- tb_vga_scanout.sv
// Testbench for the VGA scan-out engine
// Cache and memory models, row table, pixel and sync checks, watchdog
`timescale 1ns/1ps

module tb_vga_scanout;

  import vga_pkg::*;

  localparam int ADR_W   = 20;
  localparam int FIFO_AW = 6;
  localparam int NROWS   = 5;
  // Cycles per row for reset, first burst and final miss
  localparam int MARGIN  = 600;

  // One test row
  typedef struct packed {
    raster_cfg_t cfg;
    logic [19:0] start;
    logic [15:0] seed;
    logic [7:0]  frames;
    logic [7:0]  hit_pct;
  } row_t;

  logic             clk;
  logic             rst;
  raster_cfg_t      cfg_i;
  logic [ADR_W-1:0] start_addr_i;
  logic             pal_we_i;
  logic [3:0]       pal_addr_i;
  rgb_t             pal_data_i;
  logic             dcb_stb_o;
  logic [ADR_W-1:0] dcb_adr_o;
  logic [15:0]      dcb_dat_i = '0;
  logic             dcb_hit_i = 1'b0;
  logic             mem_stb_o;
  logic [ADR_W-1:0] mem_adr_o;
  logic             mem_ack_i = 1'b0;
  logic [15:0]      mem_dat_i = '0;
  rgb_t             rgb_o;
  logic             hsync_o;
  logic             vsync_o;
  logic             pix_stb_o;
  logic             underflow_o;

  row_t        rows [NROWS];
  rgb_t        exp_pal [16];
  logic [31:0] rng = 32'hfae2;
  int          cur_hit = 0;
  int          errors;
  int          checks;
  int          cycles = 0;
  int          limit = 0;

  // Model state, cleared by reset
  logic       dcb_prev;
  logic       mem_prev;
  logic       mem_pend;
  logic       miss_open;
  logic [1:0] mem_wait;
  logic [2:0] mem_idx;
  int         misses;
  int         mem_rises;

  vga_scanout #(.ADR_W(ADR_W), .FIFO_AW(FIFO_AW)) i_dut (
    .clk, .rst, .cfg_i, .start_addr_i,
    .pal_we_i, .pal_addr_i, .pal_data_i,
    .dcb_stb_o, .dcb_adr_o, .dcb_dat_i, .dcb_hit_i,
    .mem_stb_o, .mem_adr_o, .mem_ack_i, .mem_dat_i,
    .rgb_o, .hsync_o, .vsync_o, .pix_stb_o, .underflow_o
  );

  always #10 clk = ~clk;

  // xorshift32 step
  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Framebuffer content, mixes every address bit
  function automatic logic [15:0] mem_word(input logic [19:0] addr);
    logic [31:0] mix;
    mix = {12'd0, addr} * 32'h9e3779b1;
    return mix[31:16] ^ {addr[3:0], addr[19:8]};
  endfunction

  // Base palette, entry seed[3:0] replaced by seed[15:4]
  function automatic rgb_t pal_colour(input logic [15:0] seed, input int idx);
    if (idx == int'(seed[3:0])) begin
      return rgb_t'(seed[15:4]);
    end
    return rgb_t'(12'(idx * 12'h2c7 + 12'h1a4));
  endfunction

  function automatic raster_cfg_t make_cfg(input int ht, input int hv, input int hss,
                                           input int hse, input int vt, input int vv,
                                           input int vss, input int vse);
    return '{10'(ht), 10'(hv), 10'(hss), 10'(hse), 10'(vt), 10'(vv), 10'(vss), 10'(vse)};
  endfunction

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input int pix);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: rgb at pixel %0d got %h expected %h", $time, pix, got, exp);
    end
  endtask

  task automatic check_sync(input logic [1:0] got, input logic [1:0] exp, input int pix);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: h/v sync at pixel %0d got %b expected %b", $time, pix, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // Cache and memory models in one block, random draws in a fixed order
  always @(posedge clk) begin : port_models
    logic       hit;
    logic [1:0] wait_now;
    if (rst) begin
      dcb_hit_i <= 1'b0;
      dcb_dat_i <= '0;
      mem_ack_i <= 1'b0;
      mem_dat_i <= '0;
      dcb_prev  <= 1'b0;
      mem_prev  <= 1'b0;
      mem_pend  <= 1'b0;
      mem_wait  <= '0;
      mem_idx   <= '0;
      miss_open <= 1'b0;
      misses    <= 0;
      mem_rises <= 0;
    end else begin
      dcb_prev <= dcb_stb_o;
      mem_prev <= mem_stb_o;
      // Cache answers one cycle after each address
      if (dcb_stb_o) begin
        dcb_dat_i <= mem_word(dcb_adr_o);
        // Hit or miss drawn once per burst
        if (!dcb_prev) begin
          hit = (next_random() % 32'd100) < 32'(cur_hit);
          dcb_hit_i <= hit;
          if (!hit) begin
            misses    <= misses + 1;
            miss_open <= 1'b1;
          end
        end
      end
      if (mem_stb_o && !mem_prev) begin
        mem_rises <= mem_rises + 1;
        miss_open <= 1'b0;
      end
      mem_ack_i <= 1'b0;
      if (mem_stb_o && mem_ack_i) begin
        // Word 0 taken, words 1 to 7 follow
        mem_dat_i <= mem_word(mem_adr_o + ADR_W'(1));
        mem_idx   <= 3'd2;
      end else if (mem_idx != 3'd0) begin
        mem_dat_i <= mem_word(mem_adr_o + ADR_W'(mem_idx));
        mem_idx   <= (mem_idx == 3'd7) ? 3'd0 : mem_idx + 3'd1;
      end else if (mem_stb_o) begin
        // 0 to 3 cycles before the acknowledge
        wait_now = mem_pend ? mem_wait : 2'(next_random() % 32'd4);
        mem_pend <= 1'b1;
        if (wait_now == 2'd0) begin
          mem_ack_i <= 1'b1;
          mem_dat_i <= mem_word(mem_adr_o);
          mem_pend  <= 1'b0;
        end else begin
          mem_wait <= wait_now - 2'd1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic run_row(input int r);
    row_t        row;
    int          fs;
    int          total;
    int          p;
    int          pos;
    int          h;
    int          v;
    int          err0;
    logic        vis;
    logic [15:0] w;
    rgb_t        exp_rgb;
    logic [1:0]  exp_sync;
    row   = rows[r];
    fs    = int'(row.cfg.h_total) * int'(row.cfg.v_total);
    total = fs * int'(row.frames);
    err0  = errors;
    // Reset for 16 cycles, palette loaded meanwhile
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      rst          <= 1'b1;
      cfg_i        <= row.cfg;
      start_addr_i <= row.start;
      cur_hit      <= int'(row.hit_pct);
      pal_we_i     <= 1'b1;
      pal_addr_i   <= 4'(i);
      pal_data_i   <= pal_colour(row.seed, i);
      exp_pal[i]   = pal_colour(row.seed, i);
    end
    @(posedge clk);
    rst      <= 1'b0;
    pal_we_i <= 1'b0;
    p = 0;
    // Pixel beats rebuild the raster position
    while (p < total) begin
      @(negedge clk);
      if (pix_stb_o) begin
        pos = p % fs;
        h   = pos % int'(row.cfg.h_total);
        v   = pos / int'(row.cfg.h_total);
        vis = (h < int'(row.cfg.h_visible)) && (v < int'(row.cfg.v_visible));
        w   = mem_word(20'(row.start + 20'(pos)));
        exp_rgb = vis ? exp_pal[w[3:0]] : '0;
        exp_sync[1] = (h >= int'(row.cfg.h_sync_start)) && (h < int'(row.cfg.h_sync_end));
        exp_sync[0] = (v >= int'(row.cfg.v_sync_start)) && (v < int'(row.cfg.v_sync_end));
        check_count(int'(underflow_o), 0, "underflow flag");
        check_rgb(rgb_o, exp_rgb, p);
        check_sync({hsync_o, vsync_o}, exp_sync, p);
        p++;
      end
    end
    // Let a pending miss reach the memory port
    while (miss_open) begin
      @(posedge clk);
    end
    check_count(mem_rises, misses, "memory requests against cache misses");
    $display("Row %0d: %0d pixels, %0d misses, %0d errors", r, p, misses, errors - err0);
  endtask

  initial begin
    raster_cfg_t cfg_a;
    raster_cfg_t cfg_b;
    clk          = 1'b0;
    rst          = 1'b1;
    cfg_i        = '0;
    start_addr_i = '0;
    pal_we_i     = 1'b0;
    pal_addr_i   = '0;
    pal_data_i   = '0;
    errors       = 0;
    checks       = 0;
    // Frames of 240 and 256 positions
    cfg_a = make_cfg(24, 16, 18, 21, 10, 6, 7, 8);
    cfg_b = make_cfg(32, 20, 24, 28, 8, 5, 6, 7);
    // cfg, start, palette seed, frames, hit percent
    // Rows 0 to 2 differ only in cache hit rate
    rows[0] = '{cfg_a, 20'h01000, 16'h0a53, 8'd2, 8'd100};
    rows[1] = '{cfg_a, 20'h01000, 16'h0a53, 8'd2, 8'd0};
    rows[2] = '{cfg_a, 20'h01000, 16'h0a53, 8'd2, 8'd50};
    rows[3] = '{cfg_a, 20'h01000, 16'hf0c3, 8'd1, 8'd50};
    rows[4] = '{cfg_b, 20'hfff80, 16'h5a7e, 8'd2, 8'd70};
    for (int r = 0; r < NROWS; r++) begin
      limit = limit + int'(rows[r].frames) * int'(rows[r].cfg.h_total)
              * int'(rows[r].cfg.v_total) * 4 + MARGIN;
    end
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    $display("Done: %0d rows, %0d checks, %0d errors", NROWS, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
vga_pkg.sv
raster_timing.sv
burst_fetch.sv
pixel_fifo.sv
palette_out.sv
vga_scanout.sv
vga_scanout_assert.sv
tb_vga_scanout.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_vga_scanout
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
